// File: Bender.yml
package:
  name: stringAccel

sources:
  - hw/stringAccelPkg.sv
  - hw/avalonRegs.sv
  - hw/stringBuffers.sv
  - hw/spliceEngine.sv
  - hw/stringAccelTop.sv
  - target: simulation
    files:
      - bench/stringAccelTb.sv

// File: bench/stringAccelTb.sv
// Testbench for the splice accelerator
// Bus tasks, splice model, case table and compare tasks
`timescale 1ns/1ns
`default_nettype none

module stringAccelTb;

	localparam int NumCases  = 7;
	localparam int PollLimit = 200; // Cycles allowed for done to change

	typedef struct packed {
		logic [3:0] idx;       // Window start
		logic [7:0] len;       // Window length
		logic       tryWriteA; // Attempt A write while done
	} spliceCase;

	logic clk;
	logic reset;
	logic read;
	logic write;
	logic chipselect;
	stringAccelPkg::busAddr address;
	stringAccelPkg::busWord writedata;
	stringAccelPkg::busWord readdata;

	stringAccelPkg::busWord refA [stringAccelPkg::MaxWords]; // Words last written to A
	stringAccelPkg::busWord refB [stringAccelPkg::MaxWords];
	logic [31:0] rngState;
	int errorCount;
	int checkCount;
	spliceCase caseTable [NumCases];

	stringAccelTop u_dut (
		.clk(clk), .reset(reset), .read(read), .write(write), .chipselect(chipselect),
		.address(address), .writedata(writedata), .readdata(readdata)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic nextRandom(output stringAccelPkg::busWord value);
		rngState = xorshift32(rngState);
		value    = rngState;
	endtask

	// Expected Result word from the splice rule
	function automatic stringAccelPkg::busWord expectedWord(input int w, input int idx,
		input int len);
		stringAccelPkg::busWord word;
		stringAccelPkg::strChar ch;
		int lane;
		int pos;
		int src;
		word = '0;
		for (lane = 0; lane < stringAccelPkg::CharsPerWord; lane++) begin
			pos = w * stringAccelPkg::CharsPerWord + lane; // Low byte first
			if (pos >= idx && pos - idx < len) begin
				src = pos - idx;                           // B from position zero
				ch  = refB[src / 4][8 * (src % 4) +: 8];
			end else begin
				ch = refA[w][8 * lane +: 8];
			end
			word[8 * lane +: 8] = ch;
		end
		return word;
	endfunction

	task automatic checkWord(input string name, input stringAccelPkg::busWord got,
		input stringAccelPkg::busWord exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic checkDone(input logic got, input logic exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("[FAIL] done: got 0x%h, expected 0x%h", got, exp);
		end
	endtask

	task automatic busWrite(input int addr, input stringAccelPkg::busWord data);
		@(negedge clk);
		write      = 1'b1;
		chipselect = 1'b1;
		address    = stringAccelPkg::busAddr'(addr);
		writedata  = data;
		@(negedge clk);
		write      = 1'b0;
		chipselect = 1'b0;
	endtask

	task automatic busRead(input int addr, output stringAccelPkg::busWord data);
		@(negedge clk);
		read       = 1'b1;
		chipselect = 1'b1;
		address    = stringAccelPkg::busAddr'(addr);
		@(negedge clk);
		data       = readdata; // Valid one cycle after the strobe
		read       = 1'b0;
		chipselect = 1'b0;
	endtask

	// Poll control bit 0 until it reaches level
	task automatic waitDoneLevel(input logic level);
		stringAccelPkg::busWord rd;
		int cycles;
		logic seen;
		cycles = 0;
		seen   = 1'b0;
		while (!seen && cycles < PollLimit) begin
			busRead(0, rd);
			cycles += 2;
			seen = (rd[0] === level);
		end
		if (!seen) begin
			errorCount++;
			$display("Timeout: done did not reach %0d within %0d cycles", level, PollLimit);
			$display("Checks: %0d, errors: %0d", checkCount, errorCount);
			$display("TEST FAILED");
			$finish;
		end
	endtask

	initial begin
		stringAccelPkg::busWord rd;
		stringAccelPkg::busWord ctrlWord;
		spliceCase cur;
		int c;
		int w;
		int a;
		reset      = 1'b1;
		read       = 1'b0;
		write      = 1'b0;
		chipselect = 1'b0;
		address    = '0;
		writedata  = '0;
		rngState   = 32'hc5f68996;
		errorCount = 0;
		checkCount = 0;
		caseTable[0] = {4'd0, 8'd0, 1'b0};   // Zero length gives A
		caseTable[1] = {4'd3, 8'd5, 1'b1};
		caseTable[2] = {4'd10, 8'd40, 1'b0}; // Runs past character 31
		caseTable[3] = {4'd15, 8'd255, 1'b1};
		caseTable[4] = {4'd0, 8'd32, 1'b0};  // All of B
		caseTable[5] = {4'd12, 8'd20, 1'b1}; // Ends exactly at 31
		caseTable[6] = {4'd7, 8'd1, 1'b0};
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		busRead(0, rd);
		checkWord("readdata ctrl after reset", rd, '0);
		busRead(1, rd);
		checkWord("readdata A0 after reset", rd, '0);
		busRead(9, rd);
		checkWord("readdata B0 after reset", rd, '0);

		busWrite(0, 32'h0000_3ffd);                  // Sets bit 0 with go clear
		busRead(0, rd);
		checkWord("readdata ctrl", rd, 32'h0000_3ffc); // done is read-only
		busWrite(0, '0);

		for (a = 17; a < 32; a++) begin
			busWrite(a, 32'hdeadbeef);
			busRead(a, rd);
			checkWord($sformatf("readdata unmapped %0d", a), rd, '0);
		end
		busRead(1, rd);
		checkWord("readdata A0 after unmapped writes", rd, '0);
		busRead(9, rd);
		checkWord("readdata B0 after unmapped writes", rd, '0);

		for (c = 0; c < NumCases; c++) begin
			cur = caseTable[c];
			for (w = 0; w < stringAccelPkg::MaxWords; w++) begin
				nextRandom(refA[w]);
				nextRandom(refB[w]);
				busWrite(1 + w, refA[w]);
				busWrite(9 + w, refB[w]);
			end
			for (w = 0; w < stringAccelPkg::MaxWords; w++) begin
				busRead(1 + w, rd);
				checkWord($sformatf("readdata A%0d", w), rd, refA[w]);
				busRead(9 + w, rd);
				checkWord($sformatf("readdata B%0d", w), rd, refB[w]);
			end
			ctrlWord = {18'd0, cur.len, cur.idx, 1'b1, 1'b0}; // go set
			busWrite(0, ctrlWord);
			busRead(0, rd);
			checkDone(rd[0], 1'b0); // Engine still busy
			waitDoneLevel(1'b1);
			busRead(0, rd);
			checkWord("readdata ctrl done", rd, ctrlWord | 32'h1);
			for (w = 0; w < stringAccelPkg::MaxWords; w++) begin
				busRead(1 + w, rd);
				checkWord($sformatf("readdata result%0d case %0d", w, c), rd,
					expectedWord(w, cur.idx, cur.len));
			end
			if (cur.tryWriteA) begin
				for (w = 0; w < stringAccelPkg::MaxWords; w++) begin
					busWrite(1 + w, ~refA[w]); // Locked while done
				end
				for (w = 0; w < stringAccelPkg::MaxWords; w++) begin
					busRead(1 + w, rd);
					checkWord($sformatf("readdata result%0d locked", w), rd,
						expectedWord(w, cur.idx, cur.len));
				end
			end
			busWrite(0, ctrlWord & ~32'h2); // Release engine
			waitDoneLevel(1'b0);
			for (w = 0; w < stringAccelPkg::MaxWords; w++) begin
				busRead(1 + w, rd);
				checkWord($sformatf("readdata A%0d after release", w), rd, refA[w]);
			end
		end

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/avalonRegs.sv
// Bus slave with address decode, control register
// and registered read data
`timescale 1ns/1ns
`default_nettype none

module avalonRegs (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     read,
	input  logic                     write,
	input  logic                     chipselect,
	input  stringAccelPkg::busAddr   address,
	input  stringAccelPkg::busWord   writedata,
	output stringAccelPkg::busWord   readdata,
	input  logic                     done,         // Engine status in control bit 0
	output logic                     go,
	output stringAccelPkg::charIdx   spliceIndex,
	output stringAccelPkg::spliceLen spliceLength,
	output logic                     busWe,
	output logic                     busSel,       // 0 selects A, 1 selects B
	output stringAccelPkg::wordIdx   busWordAddr,
	output stringAccelPkg::busWord   busWrData,
	input  stringAccelPkg::busWord   busRdA,
	input  stringAccelPkg::busWord   busRdB,
	input  stringAccelPkg::busWord   busRdRes
);

	logic [31:1] ctrlBits; // Control bits above done
	logic ctrlHit;
	logic aHit;
	logic bHit;
	stringAccelPkg::busAddr aOffset; // Address minus A base
	stringAccelPkg::busWord rdMux;

	// Region decode
	assign ctrlHit = (address == '0);
	assign aHit    = (address >= 1) && (address <= stringAccelPkg::MaxWords);
	assign bHit    = (address > stringAccelPkg::MaxWords) &&
		(address <= 2 * stringAccelPkg::MaxWords);

	// A and B bases are 8 words apart and share the low offset bits
	assign aOffset = address - stringAccelPkg::busAddr'(1);

	// Word port towards the buffers
	assign busSel      = bHit;
	assign busWordAddr = aOffset[2:0];
	assign busWrData   = writedata;
	assign busWe       = write && chipselect && ((aHit && !done) || bHit); // A locked while done

	// Index field is only 4 bits wide
	assign go           = ctrlBits[1];
	assign spliceIndex  = {1'b0, ctrlBits[5:2]};
	assign spliceLength = ctrlBits[13:6];

	// Control register without a stored bit 0
	always_ff @(posedge clk) begin
		if (reset) begin
			ctrlBits <= '0;
		end else if (ctrlHit && write && chipselect) begin
			ctrlBits <= writedata[31:1];
		end
	end

	// Read source select
	always_comb begin
		rdMux = '0; // Unmapped addresses
		if (ctrlHit) begin
			rdMux = {ctrlBits, done};
		end else if (aHit) begin
			rdMux = done ? busRdRes : busRdA; // Result shows through A while done
		end else if (bHit) begin
			rdMux = busRdB;
		end
	end

	// Read data held between reads
	always_ff @(posedge clk) begin
		if (reset) begin
			readdata <= '0;
		end else if (read && chipselect) begin
			readdata <= rdMux;
		end
	end

endmodule

`default_nettype wire

// File: hw/spliceEngine.sv
// Splice FSM, one result character per cycle
`timescale 1ns/1ns
`default_nettype none

module spliceEngine (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     go,
	input  stringAccelPkg::charIdx   spliceIndex,
	input  stringAccelPkg::spliceLen spliceLength,
	output stringAccelPkg::charIdx   engCharAddr,  // Read address for A and B
	input  stringAccelPkg::strChar   aChar,
	input  stringAccelPkg::strChar   bChar,
	output logic                     resWe,
	output stringAccelPkg::charIdx   resCharAddr,
	output stringAccelPkg::strChar   resChar,
	output logic                     done
);

	stringAccelPkg::engState state;
	logic goPrev;
	logic goRise;
	stringAccelPkg::charIdx rdPos;     // Position being read this cycle
	stringAccelPkg::charIdx idxReg;    // Latched window start
	stringAccelPkg::spliceLen lenReg;  // Latched window length
	stringAccelPkg::charIdx winOffset; // Position within B
	logic inWindow;

	assign goRise = go && !goPrev;

	// Window test, positions past 31 never occur so overrun is dropped
	assign winOffset = rdPos - idxReg;
	assign inWindow  = (rdPos >= idxReg) &&
		(stringAccelPkg::spliceLen'(winOffset) < lenReg);

	// Inside the window only B is needed, outside only A
	assign engCharAddr = inWindow ? winOffset : rdPos;

	// Window parameters captured on the go edge
	always_ff @(posedge clk) begin
		if (state == stringAccelPkg::Idle && goRise) begin
			idxReg <= spliceIndex;
			lenReg <= spliceLength;
		end
	end

	// Write stage, one cycle behind the read address
	always_ff @(posedge clk) begin
		if (state == stringAccelPkg::Run) begin
			resCharAddr <= rdPos;
			resChar     <= inWindow ? bChar : aChar;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state  <= stringAccelPkg::Idle;
			goPrev <= 1'b0;
			rdPos  <= '0;
			resWe  <= 1'b0;
			done   <= 1'b0;
		end else begin
			goPrev <= go;
			case (state)
				stringAccelPkg::Idle: begin
					resWe <= 1'b0;
					if (goRise) begin
						rdPos <= '0;
						state <= stringAccelPkg::Run;
					end
				end
				stringAccelPkg::Run: begin
					resWe <= 1'b1;                 // Writes previous position
					rdPos <= rdPos + 1'b1;
					if (rdPos == stringAccelPkg::charIdx'(stringAccelPkg::MaxChars - 1)) begin
						state <= stringAccelPkg::Finish;
					end
				end
				stringAccelPkg::Finish: begin
					resWe <= 1'b0;                 // Last character lands here
					if (done && !go) begin
						done  <= 1'b0;             // Released by software
						state <= stringAccelPkg::Idle;
					end else begin
						done <= 1'b1;
					end
				end
				default: begin
					state <= stringAccelPkg::Idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/stringAccelPkg.sv
// Shared geometry constants, vector types and engine state encoding
// for the string splice accelerator
`default_nettype none

package stringAccelPkg;

	localparam int MaxWords     = 8;                       // Words per string
	localparam int CharsPerWord = 4;                       // Byte lanes per word
	localparam int MaxChars     = MaxWords * CharsPerWord; // 32 characters per string
	localparam int AddrBits     = 5;                       // Bus address width, 0..16 used

	// Bus data, also one word of a string
	typedef logic [31:0] busWord;

	// Bus word address
	typedef logic [AddrBits-1:0] busAddr;

	// Word select inside a string
	typedef logic [2:0] wordIdx;

	// Character position 0..31
	typedef logic [4:0] charIdx;

	// One character
	typedef logic [7:0] strChar;

	// Window length from the control register
	typedef logic [7:0] spliceLen;

	// Engine FSM
	typedef enum logic [1:0] {
		Idle,   // Waiting for a go edge
		Run,    // Stepping through the 32 positions
		Finish  // Last write drains, done held until go drops
	} engState;

endpackage

`default_nettype wire

// File: hw/stringAccelTop.sv
// Top level of the accelerator: bus slave, string buffers, splice engine
`timescale 1ns/1ns
`default_nettype none

module stringAccelTop (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   read,
	input  logic                   write,
	input  logic                   chipselect,
	input  stringAccelPkg::busAddr address,
	input  stringAccelPkg::busWord writedata,
	output stringAccelPkg::busWord readdata
);

	// Slave to buffers
	logic busWe;
	logic busSel;
	stringAccelPkg::wordIdx busWordAddr;
	stringAccelPkg::busWord busWrData;
	stringAccelPkg::busWord busRdA;
	stringAccelPkg::busWord busRdB;
	stringAccelPkg::busWord busRdRes;

	// Slave to engine
	logic go;
	logic done;
	stringAccelPkg::charIdx spliceIndex;
	stringAccelPkg::spliceLen spliceLength;

	// Engine to buffers
	stringAccelPkg::charIdx engCharAddr;
	stringAccelPkg::strChar aChar;
	stringAccelPkg::strChar bChar;
	logic resWe;
	stringAccelPkg::charIdx resCharAddr;
	stringAccelPkg::strChar resChar;

	avalonRegs u_regs (
		.clk(clk), .reset(reset), .read(read), .write(write), .chipselect(chipselect),
		.address(address), .writedata(writedata), .readdata(readdata), .done(done),
		.go(go), .spliceIndex(spliceIndex), .spliceLength(spliceLength),
		.busWe(busWe), .busSel(busSel), .busWordAddr(busWordAddr), .busWrData(busWrData),
		.busRdA(busRdA), .busRdB(busRdB), .busRdRes(busRdRes)
	);

	stringBuffers u_buffers (
		.clk(clk), .reset(reset), .busWe(busWe), .busSel(busSel),
		.busWordAddr(busWordAddr), .busWrData(busWrData),
		.busRdA(busRdA), .busRdB(busRdB), .busRdRes(busRdRes),
		.engCharAddr(engCharAddr), .aChar(aChar), .bChar(bChar),
		.resWe(resWe), .resCharAddr(resCharAddr), .resChar(resChar)
	);

	spliceEngine u_engine (
		.clk(clk), .reset(reset), .go(go),
		.spliceIndex(spliceIndex), .spliceLength(spliceLength),
		.engCharAddr(engCharAddr), .aChar(aChar), .bChar(bChar),
		.resWe(resWe), .resCharAddr(resCharAddr), .resChar(resChar), .done(done)
	);

endmodule

`default_nettype wire

// File: hw/stringBuffers.sv
// Word arrays for strings A, B and Result
// Whole-word bus port plus byte-wide engine port
`timescale 1ns/1ns
`default_nettype none

module stringBuffers (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   busWe,
	input  logic                   busSel,      // 0 writes A, 1 writes B
	input  stringAccelPkg::wordIdx busWordAddr,
	input  stringAccelPkg::busWord busWrData,
	output stringAccelPkg::busWord busRdA,
	output stringAccelPkg::busWord busRdB,
	output stringAccelPkg::busWord busRdRes,
	input  stringAccelPkg::charIdx engCharAddr,
	output stringAccelPkg::strChar aChar,
	output stringAccelPkg::strChar bChar,
	input  logic                   resWe,       // Engine byte write
	input  stringAccelPkg::charIdx resCharAddr,
	input  stringAccelPkg::strChar resChar
);

	stringAccelPkg::busWord strA   [stringAccelPkg::MaxWords];
	stringAccelPkg::busWord strB   [stringAccelPkg::MaxWords];
	stringAccelPkg::busWord strRes [stringAccelPkg::MaxWords];

	stringAccelPkg::wordIdx engWord;
	stringAccelPkg::wordIdx resWord;
	logic [1:0] engLane; // Byte lane, low byte is character 0
	logic [1:0] resLane;

	// Character position to word and lane
	assign engWord = stringAccelPkg::wordIdx'(engCharAddr / stringAccelPkg::CharsPerWord);
	assign engLane = 2'(engCharAddr % stringAccelPkg::CharsPerWord);
	assign resWord = stringAccelPkg::wordIdx'(resCharAddr / stringAccelPkg::CharsPerWord);
	assign resLane = 2'(resCharAddr % stringAccelPkg::CharsPerWord);

	// Bus side reads, same word of every string
	assign busRdA   = strA[busWordAddr];
	assign busRdB   = strB[busWordAddr];
	assign busRdRes = strRes[busWordAddr];

	// Engine side byte reads, A and B share one address
	assign aChar = strA[engWord][8*engLane +: 8];
	assign bChar = strB[engWord][8*engLane +: 8];

	always_ff @(posedge clk) begin
		if (reset) begin
			strA   <= '{default: '0}; // All strings start empty
			strB   <= '{default: '0};
			strRes <= '{default: '0};
		end else begin
			if (busWe && !busSel) begin
				strA[busWordAddr] <= busWrData;
			end
			if (busWe && busSel) begin
				strB[busWordAddr] <= busWrData;
			end
			if (resWe) begin
				strRes[resWord][8*resLane +: 8] <= resChar; // Single lane update
			end
		end
	end

endmodule

`default_nettype wire

// File: stringAccel.f
hw/stringAccelPkg.sv
hw/avalonRegs.sv
hw/stringBuffers.sv
hw/spliceEngine.sv
hw/stringAccelTop.sv
bench/stringAccelTb.sv
